// File: src.f
rtl/rvfi_pkg.sv
rtl/rvfi_amo_wdata.sv
rtl/rvfi_issue_buffer.sv
rtl/rvfi_sb_record.sv
rtl/rvfi_commit_pack.sv
rtl/rvfi_tracer.sv
verif/tb_clk_gen.sv
verif/tb_rvfi_tracer.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rvfi_tracer
SRC_F     ?= src.f
OBJ_DIR   ?= obj_dir
FLAGS     ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(SRC_F)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(SRC_F)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: verif/tb_rvfi_tracer.sv
/*
  RVFI tracer testbench with random probe traffic, a cycle model
  of issue buffer, records and commit packer, and field-by-field checks
*/
module tb_rvfi_tracer;
  timeunit 1ns;
  timeprecision 100ps;

  import rvfi_pkg::*;

  localparam int unsigned CLK_PERIOD   = 4;
  localparam int unsigned RESET_CYCLES = 10;
  localparam int unsigned NUM_CYCLES   = 4000;

  logic clk_i;
  logic rst_ni;

  fetch_t      [NR_ISSUE-1:0]  fetch;
  logic        [NR_ISSUE-1:0]  issue_ack;
  logic                        flush;
  issue_req_t  [NR_ISSUE-1:0]  issue_req;
  logic                        flush_unissued;
  lsu_probe_t                  lsu;
  commit_t     [NR_COMMIT-1:0] commit;
  exc_t                        exc;
  logic        [1:0]           priv_lvl;
  logic                        debug_mode;
  rvfi_instr_t [NR_COMMIT-1:0] rvfi;

  // --------------------
  // Reference model state
  // --------------------
  issue_slot_t [NR_ISSUE-1:0]  m_slots;
  sb_entry_t                   m_rec [NR_SB_ENTRIES];
  logic        [2:0]           m_intr [NR_COMMIT];
  rvfi_instr_t [NR_COMMIT-1:0] exp_rvfi;   // Expected after the next rising edge
  logic        [31:0]          rng_state;

  tb_clk_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) i_clk_gen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  rvfi_tracer i_dut (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .fetch_i          (fetch),
    .issue_ack_i      (issue_ack),
    .flush_i          (flush),
    .issue_req_i      (issue_req),
    .flush_unissued_i (flush_unissued),
    .lsu_i            (lsu),
    .commit_i         (commit),
    .exc_i            (exc),
    .priv_lvl_i       (priv_lvl),
    .debug_mode_i     (debug_mode),
    .rvfi_o           (rvfi)
  );

  function automatic logic [31:0] rand32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Sign bits and half-word boundaries show up often
  function automatic logic [XLEN-1:0] pick_operand();
    logic [31:0] r;
    r = rand32();
    if (r[3]) return {rand32(), rand32()};
    case (r[2:0])
      3'd0:    return 64'h0000_0000_0000_0000;
      3'd1:    return 64'hffff_ffff_ffff_ffff;
      3'd2:    return 64'h8000_0000_0000_0000;
      3'd3:    return 64'h7fff_ffff_ffff_ffff;
      3'd4:    return 64'h0000_0000_8000_0000;
      3'd5:    return 64'h0000_0000_7fff_ffff;
      3'd6:    return 64'hffff_ffff_0000_0000;
      default: return 64'h0000_0000_ffff_ffff;
    endcase
  endfunction

  // Memory write value of an AMO from the old value and the rs2 operand
  function automatic logic [XLEN-1:0] amo_value(input op_e op, input logic [XLEN-1:0] old,
                                                input logic [XLEN-1:0] rv);
    logic            word;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] res;
    logic            less_s;
    logic            less_u;
    word = op inside {OP_LR_W, OP_SC_W, OP_SWAP_W, OP_ADD_W, OP_AND_W, OP_OR_W,
                      OP_XOR_W, OP_MAX_W, OP_MAXU_W, OP_MIN_W, OP_MINU_W};
    a      = word ? {{32{old[31]}}, old[31:0]} : old;
    b      = word ? {{32{rv[31]}}, rv[31:0]} : rv;
    less_s = $signed(a) < $signed(b);
    less_u = word ? (old[31:0] < rv[31:0]) : (old < rv);
    case (op)
      OP_ADD_W, OP_ADD_D:   res = a + b;
      OP_AND_W, OP_AND_D:   res = a & b;
      OP_OR_W, OP_OR_D:     res = a | b;
      OP_XOR_W, OP_XOR_D:   res = a ^ b;
      OP_MAX_W, OP_MAX_D:   res = less_s ? b : a;
      OP_MAXU_W, OP_MAXU_D: res = less_u ? b : a;
      OP_MIN_W, OP_MIN_D:   res = less_s ? a : b;
      OP_MINU_W, OP_MINU_D: res = less_u ? a : b;
      default:              res = b;
    endcase
    return word ? {32'h0, res[31:0]} : res;
  endfunction

  task automatic check_equal(input string name, input logic [63:0] exp_val,
                             input logic [63:0] act_val);
    if (act_val !== exp_val) begin
      $display("ERROR %s: expected 0x%0h, actual 0x%0h", name, exp_val, act_val);
      $display("Finished with errors");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  // --------------------
  // Stimulus
  // --------------------
  task automatic drive_inputs();
    logic [31:0] r;
    logic [63:0] w;
    for (int i = 0; i < NR_ISSUE; i++) begin
      r = rand32();
      fetch[i].valid         = r[0];
      fetch[i].is_compressed = r[1];
      fetch[i].instr         = rand32();
      issue_req[i].valid     = r[2];
      issue_req[i].ack       = r[3] | r[4];
      issue_req[i].trans_id  = r[7:5];
      issue_req[i].rs1_rdata = {rand32(), rand32()};
      issue_req[i].rs2_rdata = pick_operand();
      issue_ack[i]           = r[2] & (r[3] | r[4]);  // Buffer sees the core's issue
    end
    r = rand32();
    w = {rand32(), rand32()};
    flush           = (r[3:0] == 4'd0);
    flush_unissued  = (r[7:4] == 4'd0);
    lsu.is_load     = r[8];
    lsu.is_store    = r[9];
    lsu.be          = r[10] ? 8'h00 : r[18:11];
    lsu.trans_id    = r[21:19];
    lsu.vaddr       = w[VLEN-1:0];
    lsu.store_wdata = {rand32(), rand32()};
    for (int i = 0; i < NR_COMMIT; i++) begin
      r = rand32();
      w = {rand32(), rand32()};
      commit[i].valid    = r[0] | r[1];
      commit[i].ack      = commit[i].valid & (r[2] | r[3]);
      commit[i].drop     = r[4] & r[5];
      commit[i].trans_id = r[8:6];
      commit[i].pc       = w[VLEN-1:0];
      commit[i].op       = op_e'(r[14:9] % 6'd25);
      commit[i].rs1      = r[19:15];
      commit[i].rs2      = r[24:20];
      commit[i].rd       = r[29:25];
      commit[i].result   = {rand32(), rand32()};
      // Sometimes equal to the recorded rs2 to hit the equal case of the AMO compare
      commit[i].wdata    = (r[30] & r[31]) ? m_rec[r[8:6]].rs2_rdata : pick_operand();
    end
    r = rand32();
    exc.valid = (r[1:0] == 2'd0);
    case (r[3:2])
      2'd0: begin
        exc.cause = (r[5:4] == 2'd0) ? ENV_CALL_UMODE :
                    (r[5:4] == 2'd1) ? ENV_CALL_SMODE : ENV_CALL_MMODE;
      end
      2'd1:    exc.cause = {1'b1, 59'd0, r[7:4]};  // Interrupt
      default: exc.cause = {58'd0, r[9:4]};
    endcase
    priv_lvl   = r[11:10];
    debug_mode = r[12] & r[13];
  endtask

  // --------------------
  // Reference model, one rising edge
  // --------------------
  task automatic step_model();
    issue_slot_t [NR_ISSUE-1:0] cut;
    sb_entry_t                  rec;
    logic                       env_call;
    logic                       irq;
    logic                       hit;
    logic                       ret;
    logic                       took0;
    env_call = exc.cause inside {ENV_CALL_UMODE, ENV_CALL_SMODE, ENV_CALL_MMODE};
    irq      = exc.cause[CAUSE_IRQ_BIT];

    // Commits see the records as they stood before this edge
    for (int i = 0; i < NR_COMMIT; i++) begin
      rec = m_rec[commit[i].trans_id];
      hit = (i == 0) && commit[i].valid && exc.valid && !commit[i].drop;
      ret = (commit[i].ack && !commit[i].drop && !exc.valid) || (hit && env_call);
      exp_rvfi[i].valid     = ret;
      exp_rvfi[i].insn      = rec.instr;
      exp_rvfi[i].trap      = hit && !irq;
      exp_rvfi[i].intr      = m_intr[i];
      exp_rvfi[i].cause     = exc.cause;
      exp_rvfi[i].mode      = debug_mode ? PRIV_DEBUG : priv_lvl;
      exp_rvfi[i].rs1_addr  = commit[i].rs1;
      exp_rvfi[i].rs2_addr  = commit[i].rs2;
      exp_rvfi[i].rd_addr   = commit[i].rd;
      exp_rvfi[i].rs1_rdata = rec.rs1_rdata;
      exp_rvfi[i].rs2_rdata = rec.rs2_rdata;
      exp_rvfi[i].rd_wdata  = commit[i].wdata;
      exp_rvfi[i].pc_rdata  = commit[i].pc;
      exp_rvfi[i].mem_addr  = rec.lsu_addr;
      exp_rvfi[i].mem_rmask = rec.lsu_rmask;
      exp_rvfi[i].mem_wmask = rec.lsu_wmask;
      exp_rvfi[i].mem_rdata = commit[i].result;
      if (commit[i].op inside {OP_OTHER, OP_LOAD, OP_STORE}) begin
        exp_rvfi[i].mem_wdata = rec.lsu_wdata;
      end else begin
        exp_rvfi[i].mem_wdata = amo_value(commit[i].op, commit[i].wdata, rec.rs2_rdata);
      end
      if (ret) begin
        m_intr[i] = 3'b000;
      end else if (hit) begin
        m_intr[i] = irq ? INTR_IRQ : INTR_EXC;
      end
    end

    for (int i = 0; i < NR_ISSUE; i++) begin
      if (issue_req[i].valid && issue_req[i].ack && !flush_unissued) begin
        m_rec[issue_req[i].trans_id]           = '0;
        m_rec[issue_req[i].trans_id].rs1_rdata = issue_req[i].rs1_rdata;
        m_rec[issue_req[i].trans_id].rs2_rdata = issue_req[i].rs2_rdata;
        m_rec[issue_req[i].trans_id].instr     = m_slots[i].instr;
      end
    end
    if (lsu.is_load && lsu.be != 8'h00) begin
      m_rec[lsu.trans_id].lsu_addr  = lsu.vaddr;
      m_rec[lsu.trans_id].lsu_rmask = lsu.be;
    end else if (lsu.is_store && lsu.be != 8'h00) begin
      m_rec[lsu.trans_id].lsu_addr  = lsu.vaddr;
      m_rec[lsu.trans_id].lsu_wmask = lsu.be;
      m_rec[lsu.trans_id].lsu_wdata = lsu.store_wdata;
    end

    // Issue buffer refill order
    for (int i = 0; i < NR_ISSUE; i++) begin
      cut[i].valid         = fetch[i].valid;
      cut[i].is_compressed = fetch[i].is_compressed;
      cut[i].instr         = fetch[i].is_compressed ? {16'h0, fetch[i].instr[15:0]} :
                                                      fetch[i].instr;
      if (issue_ack[i]) m_slots[i].valid = 1'b0;
    end
    took0 = 1'b0;
    if (!m_slots[1].valid) begin
      m_slots[1] = cut[0];
      took0      = 1'b1;
    end
    if (!m_slots[0].valid) begin
      m_slots[0]       = m_slots[1];
      m_slots[1].valid = 1'b0;
    end
    if (!m_slots[1].valid) m_slots[1] = took0 ? cut[1] : cut[0];
    if (flush) begin
      m_slots[0].valid = 1'b0;
      m_slots[1].valid = 1'b0;
    end
  endtask

  task automatic check_outputs(input int cycle);
    string tag;
    for (int i = 0; i < NR_COMMIT; i++) begin
      tag = $sformatf("cycle %0d port%0d", cycle, i);
      check_equal({tag, " valid"}, 64'(exp_rvfi[i].valid), 64'(rvfi[i].valid));
      check_equal({tag, " insn"}, 64'(exp_rvfi[i].insn), 64'(rvfi[i].insn));
      check_equal({tag, " trap"}, 64'(exp_rvfi[i].trap), 64'(rvfi[i].trap));
      check_equal({tag, " intr"}, 64'(exp_rvfi[i].intr), 64'(rvfi[i].intr));
      check_equal({tag, " cause"}, exp_rvfi[i].cause, rvfi[i].cause);
      check_equal({tag, " mode"}, 64'(exp_rvfi[i].mode), 64'(rvfi[i].mode));
      check_equal({tag, " rs1_addr"}, 64'(exp_rvfi[i].rs1_addr), 64'(rvfi[i].rs1_addr));
      check_equal({tag, " rs2_addr"}, 64'(exp_rvfi[i].rs2_addr), 64'(rvfi[i].rs2_addr));
      check_equal({tag, " rd_addr"}, 64'(exp_rvfi[i].rd_addr), 64'(rvfi[i].rd_addr));
      check_equal({tag, " rs1_rdata"}, exp_rvfi[i].rs1_rdata, rvfi[i].rs1_rdata);
      check_equal({tag, " rs2_rdata"}, exp_rvfi[i].rs2_rdata, rvfi[i].rs2_rdata);
      check_equal({tag, " rd_wdata"}, exp_rvfi[i].rd_wdata, rvfi[i].rd_wdata);
      check_equal({tag, " pc_rdata"}, 64'(exp_rvfi[i].pc_rdata), 64'(rvfi[i].pc_rdata));
      check_equal({tag, " mem_addr"}, 64'(exp_rvfi[i].mem_addr), 64'(rvfi[i].mem_addr));
      check_equal({tag, " mem_rmask"}, 64'(exp_rvfi[i].mem_rmask), 64'(rvfi[i].mem_rmask));
      check_equal({tag, " mem_wmask"}, 64'(exp_rvfi[i].mem_wmask), 64'(rvfi[i].mem_wmask));
      check_equal({tag, " mem_wdata"}, exp_rvfi[i].mem_wdata, rvfi[i].mem_wdata);
      check_equal({tag, " mem_rdata"}, exp_rvfi[i].mem_rdata, rvfi[i].mem_rdata);
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    rng_state      = 32'h107e2dcc;
    fetch          = '0;
    issue_ack      = '0;
    flush          = 1'b0;
    issue_req      = '0;
    flush_unissued = 1'b0;
    lsu            = '0;
    commit         = '0;
    exc            = '0;
    priv_lvl       = 2'd0;
    debug_mode     = 1'b0;
    m_slots        = '0;
    exp_rvfi       = '0;
    for (int i = 0; i < NR_SB_ENTRIES; i++) m_rec[i] = '0;
    for (int i = 0; i < NR_COMMIT; i++) m_intr[i] = 3'b000;

    wait (rst_ni === 1'b1);
    for (int i = 0; i < NR_COMMIT; i++) begin
      check_equal($sformatf("reset port%0d valid", i), 64'd0, 64'(rvfi[i].valid));
      check_equal($sformatf("reset port%0d trap", i), 64'd0, 64'(rvfi[i].trap));
      check_equal($sformatf("reset port%0d intr", i), 64'd0, 64'(rvfi[i].intr));
    end

    @(negedge clk_i);
    drive_inputs();
    step_model();
    for (int n = 0; n < NUM_CYCLES; n++) begin
      @(negedge clk_i);
      drive_inputs();  // Next inputs already applied, so the outputs must come from the edge
      #(CLK_PERIOD / 4);
      check_outputs(n);
      step_model();
    end

    $display("Finished with no errors");
    $finish;
  end

  // Reset plus the full stimulus loop with a factor of two as margin
  initial begin
    #((RESET_CYCLES + NUM_CYCLES + 10) * CLK_PERIOD * 2);
    $display("Finished with errors");
    $fatal(1, "Watchdog timeout, the stimulus loop did not complete in time");
  end

endmodule

// File: verif/tb_clk_gen.sv
/*
  Testbench clock and active-low reset generator
*/
module tb_clk_gen #(
  parameter int unsigned PERIOD       = 4,
  parameter int unsigned RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Release lands on a falling edge
  initial begin
    rst_no = 1'b0;
    #(PERIOD * RESET_CYCLES);
    rst_no = 1'b1;
  end

endmodule

// File: rtl/rvfi_tracer.sv
/*
  RVFI tracer top: issue buffer, transaction record, commit packer
*/
module rvfi_tracer (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,
  input  rvfi_pkg::fetch_t      [rvfi_pkg::NR_ISSUE-1:0]   fetch_i,
  input  logic                  [rvfi_pkg::NR_ISSUE-1:0]   issue_ack_i,
  input  logic                                             flush_i,
  input  rvfi_pkg::issue_req_t  [rvfi_pkg::NR_ISSUE-1:0]   issue_req_i,
  input  logic                                             flush_unissued_i,
  input  rvfi_pkg::lsu_probe_t                             lsu_i,
  input  rvfi_pkg::commit_t     [rvfi_pkg::NR_COMMIT-1:0]  commit_i,
  input  rvfi_pkg::exc_t                                   exc_i,
  input  logic                  [1:0]                      priv_lvl_i,
  input  logic                                             debug_mode_i,
  output rvfi_pkg::rvfi_instr_t [rvfi_pkg::NR_COMMIT-1:0]  rvfi_o
);
  import rvfi_pkg::*;

  issue_slot_t [NR_ISSUE-1:0]  slots;       // Words waiting for issue
  sb_entry_t   [NR_COMMIT-1:0] commit_rec;  // Records at the commit trans_ids

  rvfi_issue_buffer i_issue_buffer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .fetch_i     (fetch_i),
    .issue_ack_i (issue_ack_i),
    .flush_i     (flush_i),
    .slots_o     (slots)
  );

  rvfi_sb_record i_sb_record (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .slots_i          (slots),
    .issue_req_i      (issue_req_i),
    .flush_unissued_i (flush_unissued_i),
    .lsu_i            (lsu_i),
    .commit_i         (commit_i),
    .commit_rec_o     (commit_rec)
  );

  rvfi_commit_pack i_commit_pack (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .commit_i     (commit_i),
    .exc_i        (exc_i),
    .commit_rec_i (commit_rec),
    .priv_lvl_i   (priv_lvl_i),
    .debug_mode_i (debug_mode_i),
    .rvfi_o       (rvfi_o)
  );

endmodule

// File: rtl/rvfi_commit_pack.sv
/*
  Registered retirement records, one per commit port
*/
module rvfi_commit_pack (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,
  input  rvfi_pkg::commit_t     [rvfi_pkg::NR_COMMIT-1:0]  commit_i,
  input  rvfi_pkg::exc_t                                   exc_i,
  input  rvfi_pkg::sb_entry_t   [rvfi_pkg::NR_COMMIT-1:0]  commit_rec_i,
  input  logic                  [1:0]                      priv_lvl_i,
  input  logic                                             debug_mode_i,
  output rvfi_pkg::rvfi_instr_t [rvfi_pkg::NR_COMMIT-1:0]  rvfi_o
);
  import rvfi_pkg::*;

  logic                            env_call;
  logic                            exc_irq;
  logic [NR_COMMIT-1:0]            exc_hit;   // Exception taken on this port
  logic [NR_COMMIT-1:0]            retire;
  logic [NR_COMMIT-1:0]            is_amo;
  logic [NR_COMMIT-1:0][XLEN-1:0]  amo_wdata;
  logic [NR_COMMIT-1:0][2:0]       intr_q;    // Trap entry kind of the last event

  assign env_call = exc_i.cause inside {ENV_CALL_UMODE, ENV_CALL_SMODE, ENV_CALL_MMODE};
  assign exc_irq  = exc_i.cause[CAUSE_IRQ_BIT];

  for (genvar i = 0; i < NR_COMMIT; i++) begin : g_port
    // Only the oldest port can take an exception
    assign exc_hit[i] = (i == 0) && commit_i[i].valid && exc_i.valid && !commit_i[i].drop;
    assign retire[i]  = (commit_i[i].ack && !exc_i.valid && !commit_i[i].drop) ||
                        (exc_hit[i] && env_call);
    assign is_amo[i]  = commit_i[i].op inside {[OP_LR_W:OP_MINU_D]};

    rvfi_amo_wdata i_amo_wdata (
      .op_i      (commit_i[i].op),
      .mem_old_i (commit_i[i].wdata),
      .reg_val_i (commit_rec_i[i].rs2_rdata),
      .wdata_o   (amo_wdata[i])
    );
  end

  // --------------------
  // Output registers
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvfi_o <= '0;
      intr_q <= '0;
    end else begin
      for (int i = 0; i < NR_COMMIT; i++) begin
        rvfi_o[i].valid <= retire[i];
        rvfi_o[i].trap  <= exc_hit[i] && !exc_irq;  // Synchronous trap, not executed
        rvfi_o[i].intr  <= intr_q[i];               // Value from before this commit
        rvfi_o[i].cause <= exc_i.cause;
        rvfi_o[i].mode  <= debug_mode_i ? PRIV_DEBUG : priv_lvl_i;
        rvfi_o[i].insn  <= commit_rec_i[i].instr;

        if (retire[i]) begin
          intr_q[i] <= '0;
        end else if (exc_hit[i]) begin
          intr_q[i] <= exc_irq ? INTR_IRQ : INTR_EXC;
        end

        rvfi_o[i].rs1_addr  <= commit_i[i].rs1;
        rvfi_o[i].rs2_addr  <= commit_i[i].rs2;
        rvfi_o[i].rd_addr   <= commit_i[i].rd;
        rvfi_o[i].rs1_rdata <= commit_rec_i[i].rs1_rdata;
        rvfi_o[i].rs2_rdata <= commit_rec_i[i].rs2_rdata;
        rvfi_o[i].rd_wdata  <= commit_i[i].wdata;
        rvfi_o[i].pc_rdata  <= commit_i[i].pc;
        rvfi_o[i].mem_addr  <= commit_rec_i[i].lsu_addr;
        rvfi_o[i].mem_rmask <= commit_rec_i[i].lsu_rmask;
        rvfi_o[i].mem_wmask <= commit_rec_i[i].lsu_wmask;
        rvfi_o[i].mem_wdata <= is_amo[i] ? amo_wdata[i] : commit_rec_i[i].lsu_wdata;
        rvfi_o[i].mem_rdata <= commit_i[i].result;
      end
    end
  end

endmodule

// File: rtl/rvfi_sb_record.sv
/*
  Per-transaction record, written at issue and
  completed by the load/store address probe
*/
module rvfi_sb_record (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  rvfi_pkg::issue_slot_t [rvfi_pkg::NR_ISSUE-1:0]  slots_i,
  input  rvfi_pkg::issue_req_t  [rvfi_pkg::NR_ISSUE-1:0]  issue_req_i,
  input  logic                                            flush_unissued_i,
  input  rvfi_pkg::lsu_probe_t                            lsu_i,
  input  rvfi_pkg::commit_t     [rvfi_pkg::NR_COMMIT-1:0] commit_i,
  output rvfi_pkg::sb_entry_t   [rvfi_pkg::NR_COMMIT-1:0] commit_rec_o
);
  import rvfi_pkg::*;

  sb_entry_t [NR_SB_ENTRIES-1:0] mem_d;
  sb_entry_t [NR_SB_ENTRIES-1:0] mem_q;
  logic                          load_hit;
  logic                          store_hit;

  assign load_hit  = lsu_i.is_load  && (lsu_i.be != '0);
  assign store_hit = lsu_i.is_store && (lsu_i.be != '0);

  // --------------------
  // Record update
  // --------------------
  always_comb begin
    mem_d = mem_q;

    for (int i = 0; i < NR_ISSUE; i++) begin
      if (issue_req_i[i].valid && issue_req_i[i].ack && !flush_unissued_i) begin
        mem_d[issue_req_i[i].trans_id] = '{
          rs1_rdata: issue_req_i[i].rs1_rdata,
          rs2_rdata: issue_req_i[i].rs2_rdata,
          lsu_addr:  '0,
          lsu_rmask: '0,
          lsu_wmask: '0,
          lsu_wdata: '0,
          instr:     slots_i[i].instr
        };
      end
    end

    // Address phase lands after the issue write of the same cycle
    if (load_hit) begin
      mem_d[lsu_i.trans_id].lsu_addr  = lsu_i.vaddr;
      mem_d[lsu_i.trans_id].lsu_rmask = lsu_i.be;
    end else if (store_hit) begin
      mem_d[lsu_i.trans_id].lsu_addr  = lsu_i.vaddr;
      mem_d[lsu_i.trans_id].lsu_wmask = lsu_i.be;
      mem_d[lsu_i.trans_id].lsu_wdata = lsu_i.store_wdata;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '0;
    end else begin
      mem_q <= mem_d;
    end
  end

  // --------------------
  // Commit read
  // --------------------
  for (genvar i = 0; i < NR_COMMIT; i++) begin : g_read
    assign commit_rec_o[i] = mem_q[commit_i[i].trans_id];  // Sees writes from earlier cycles
  end

endmodule

// File: rtl/rvfi_issue_buffer.sv
/*
  Two-slot buffer of fetched instruction words waiting for issue
*/
module rvfi_issue_buffer (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  rvfi_pkg::fetch_t      [rvfi_pkg::NR_ISSUE-1:0] fetch_i,
  input  logic                  [rvfi_pkg::NR_ISSUE-1:0] issue_ack_i,
  input  logic                                         flush_i,
  output rvfi_pkg::issue_slot_t [rvfi_pkg::NR_ISSUE-1:0] slots_o
);
  import rvfi_pkg::*;

  localparam int unsigned LAST = NR_ISSUE - 1;

  issue_slot_t [NR_ISSUE-1:0] fetched;  // Fetch slots, compressed words cut to 16 bits
  issue_slot_t [NR_ISSUE-1:0] slots_d;
  issue_slot_t [NR_ISSUE-1:0] slots_q;
  logic                       took0;    // Fetch slot 0 already went into the last slot

  for (genvar i = 0; i < NR_ISSUE; i++) begin : g_cut
    assign fetched[i].valid         = fetch_i[i].valid;
    assign fetched[i].is_compressed = fetch_i[i].is_compressed;
    assign fetched[i].instr         = fetch_i[i].is_compressed ?
                                      {{(ILEN-16){1'b0}}, fetch_i[i].instr[15:0]} :
                                      fetch_i[i].instr;
  end

  always_comb begin
    slots_d = slots_q;
    took0   = 1'b0;

    for (int i = 0; i < NR_ISSUE; i++) begin
      if (issue_ack_i[i]) slots_d[i].valid = 1'b0;  // Taken by the core
    end

    if (!slots_d[LAST].valid) begin
      slots_d[LAST] = fetched[0];
      took0         = 1'b1;
    end

    // Oldest word moves down to slot 0
    if (!slots_d[0].valid) begin
      slots_d[0]          = slots_d[LAST];
      slots_d[LAST].valid = 1'b0;
    end

    if (!slots_d[LAST].valid) begin
      slots_d[LAST] = took0 ? fetched[LAST] : fetched[0];
    end

    if (flush_i) begin
      for (int i = 0; i < NR_ISSUE; i++) slots_d[i].valid = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slots_q <= '0;
    end else begin
      slots_q <= slots_d;
    end
  end

  assign slots_o = slots_q;

endmodule

// File: rtl/rvfi_amo_wdata.sv
/*
  Rebuilds the value an AMO writes back to memory
*/
module rvfi_amo_wdata (
  input  rvfi_pkg::op_e             op_i,
  input  logic [rvfi_pkg::XLEN-1:0] mem_old_i,  // Old memory value, as returned to rd
  input  logic [rvfi_pkg::XLEN-1:0] reg_val_i,  // rs2 operand
  output logic [rvfi_pkg::XLEN-1:0] wdata_o
);
  import rvfi_pkg::*;

  logic            is_word;
  logic            is_signed_cmp;
  logic [XLEN-1:0] a_sext;
  logic [XLEN-1:0] b_sext;
  logic [XLEN-1:0] a_zext;
  logic [XLEN-1:0] b_zext;
  logic [XLEN:0]   a_cmp;
  logic [XLEN:0]   b_cmp;
  logic            a_lt_b;
  logic [XLEN-1:0] result;

  assign is_word = op_i inside {OP_LR_W, OP_SC_W, OP_SWAP_W, OP_ADD_W, OP_AND_W, OP_OR_W,
                                OP_XOR_W, OP_MAX_W, OP_MAXU_W, OP_MIN_W, OP_MINU_W};

  assign is_signed_cmp = op_i inside {OP_MAX_W, OP_MAX_D, OP_MIN_W, OP_MIN_D};

  // --------------------
  // Operand views
  // --------------------
  always_comb begin
    if (is_word) begin
      a_sext = {{(XLEN-32){mem_old_i[31]}}, mem_old_i[31:0]};
      b_sext = {{(XLEN-32){reg_val_i[31]}}, reg_val_i[31:0]};
      a_zext = {{(XLEN-32){1'b0}}, mem_old_i[31:0]};
      b_zext = {{(XLEN-32){1'b0}}, reg_val_i[31:0]};
    end else begin
      a_sext = mem_old_i;
      b_sext = reg_val_i;
      a_zext = mem_old_i;
      b_zext = reg_val_i;
    end
  end

  // One extra bit lets the same signed compare serve both orderings
  assign a_cmp  = is_signed_cmp ? {a_sext[XLEN-1], a_sext} : {1'b0, a_zext};
  assign b_cmp  = is_signed_cmp ? {b_sext[XLEN-1], b_sext} : {1'b0, b_zext};
  assign a_lt_b = $signed(a_cmp) < $signed(b_cmp);

  // --------------------
  // Result select
  // --------------------
  always_comb begin
    case (op_i)
      OP_ADD_W, OP_ADD_D:   result = a_sext + b_sext;
      OP_AND_W, OP_AND_D:   result = a_zext & b_zext;
      OP_OR_W,  OP_OR_D:    result = a_zext | b_zext;
      OP_XOR_W, OP_XOR_D:   result = a_zext ^ b_zext;
      OP_MAX_W, OP_MAX_D,
      OP_MAXU_W, OP_MAXU_D: result = a_lt_b ? b_zext : a_zext;
      OP_MIN_W, OP_MIN_D,
      OP_MINU_W, OP_MINU_D: result = a_lt_b ? a_zext : b_zext;
      default:              result = b_zext;  // SC, SWAP, LR and plain ops
    endcase
  end

  assign wdata_o = is_word ? {{(XLEN-32){1'b0}}, result[31:0]} : result;

endmodule

// File: rtl/rvfi_pkg.sv
/*
  Fixed tracer configuration, operation encoding and the
  probe, record and retirement structs
*/
package rvfi_pkg;

  // --------------------
  // Configuration
  // --------------------
  localparam int unsigned XLEN          = 64;  // Register width
  localparam int unsigned VLEN          = 39;  // Virtual address width
  localparam int unsigned ILEN          = 32;
  localparam int unsigned NR_ISSUE      = 2;
  localparam int unsigned NR_COMMIT     = 2;
  localparam int unsigned NR_SB_ENTRIES = 8;   // One record per transaction ID
  localparam int unsigned TRANS_ID_BITS = 3;
  localparam int unsigned REG_ADDR_BITS = 5;
  localparam int unsigned BE_BITS       = 8;
  localparam int unsigned CAUSE_IRQ_BIT = 63;

  // Environment call causes retire as valid instructions
  localparam logic [XLEN-1:0] ENV_CALL_UMODE = 64'd8;
  localparam logic [XLEN-1:0] ENV_CALL_SMODE = 64'd9;
  localparam logic [XLEN-1:0] ENV_CALL_MMODE = 64'd11;

  localparam logic [1:0] PRIV_DEBUG = 2'd2;
  localparam logic [2:0] INTR_IRQ   = 3'b101;  // Entered through an interrupt
  localparam logic [2:0] INTR_EXC   = 3'b011;  // Entered through an exception

  // AMO encodings follow the plain ops, which keeps the AMO range contiguous
  typedef enum logic [5:0] {
    OP_OTHER,
    OP_LOAD,
    OP_STORE,
    OP_LR_W,   OP_LR_D,
    OP_SC_W,   OP_SC_D,
    OP_SWAP_W, OP_SWAP_D,
    OP_ADD_W,  OP_ADD_D,
    OP_AND_W,  OP_AND_D,
    OP_OR_W,   OP_OR_D,
    OP_XOR_W,  OP_XOR_D,
    OP_MAX_W,  OP_MAX_D,
    OP_MAXU_W, OP_MAXU_D,
    OP_MIN_W,  OP_MIN_D,
    OP_MINU_W, OP_MINU_D
  } op_e;

  // --------------------
  // Probe structs
  // --------------------
  typedef struct packed {
    logic            valid;
    logic [ILEN-1:0] instr;
    logic            is_compressed;
  } fetch_t;

  typedef struct packed {
    logic            valid;
    logic [ILEN-1:0] instr;
    logic            is_compressed;
  } issue_slot_t;

  typedef struct packed {
    logic                     valid;
    logic                     ack;
    logic [TRANS_ID_BITS-1:0] trans_id;
    logic [XLEN-1:0]          rs1_rdata;
    logic [XLEN-1:0]          rs2_rdata;
  } issue_req_t;

  typedef struct packed {
    logic                     is_load;
    logic                     is_store;
    logic [BE_BITS-1:0]       be;
    logic [VLEN-1:0]          vaddr;
    logic [TRANS_ID_BITS-1:0] trans_id;
    logic [XLEN-1:0]          store_wdata;
  } lsu_probe_t;

  typedef struct packed {
    logic [XLEN-1:0]    rs1_rdata;
    logic [XLEN-1:0]    rs2_rdata;
    logic [VLEN-1:0]    lsu_addr;
    logic [BE_BITS-1:0] lsu_rmask;
    logic [BE_BITS-1:0] lsu_wmask;
    logic [XLEN-1:0]    lsu_wdata;
    logic [ILEN-1:0]    instr;
  } sb_entry_t;

  typedef struct packed {
    logic                     valid;
    logic                     ack;
    logic                     drop;
    logic [TRANS_ID_BITS-1:0] trans_id;
    logic [VLEN-1:0]          pc;
    op_e                      op;
    logic [REG_ADDR_BITS-1:0] rs1;
    logic [REG_ADDR_BITS-1:0] rs2;
    logic [REG_ADDR_BITS-1:0] rd;
    logic [XLEN-1:0]          result;
    logic [XLEN-1:0]          wdata;
  } commit_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] cause;
  } exc_t;

  // --------------------
  // Retirement record
  // --------------------
  typedef struct packed {
    logic                     valid;
    logic [ILEN-1:0]          insn;
    logic                     trap;
    logic [2:0]               intr;
    logic [XLEN-1:0]          cause;
    logic [1:0]               mode;
    logic [REG_ADDR_BITS-1:0] rs1_addr;
    logic [REG_ADDR_BITS-1:0] rs2_addr;
    logic [REG_ADDR_BITS-1:0] rd_addr;
    logic [XLEN-1:0]          rs1_rdata;
    logic [XLEN-1:0]          rs2_rdata;
    logic [XLEN-1:0]          rd_wdata;
    logic [VLEN-1:0]          pc_rdata;
    logic [VLEN-1:0]          mem_addr;
    logic [BE_BITS-1:0]       mem_rmask;
    logic [BE_BITS-1:0]       mem_wmask;
    logic [XLEN-1:0]          mem_wdata;
    logic [XLEN-1:0]          mem_rdata;
  } rvfi_instr_t;

endpackage
